/* source/cpu_test_defines.svh */
// bus test parameters
// block placement, status register, wait length and micro-instruction field widths
`ifndef CPU_TEST_DEFINES_SVH
`define CPU_TEST_DEFINES_SVH

// bus and micro-sequencer widths
`define BUS_ADDR_W   22
`define WORD_W       32
`define PC_W         8

// micro-instruction fields from the msb down
`define UOP_W        4
`define REG_SEL_W    3
`define TARGET_W     6
`define UINSTR_W     (`UOP_W + 2 * `REG_SEL_W + `TARGET_W + `WORD_W)

// test block and peripheral registers
`define BLOCK_BASE   22'h000100
`define BLOCK_WORDS  64
`define STATUS_ADDR  22'h000010   // bit 0 is busy

// length of one WAIT micro-op in cycles
`define WAIT_CYCLES  16

`endif

/* source/cpu_test_pkg.sv */
// shared types of the microcoded bus test cpu
// opcodes, register selects, micro-instruction and bus words
`include "cpu_test_defines.svh"

package cpu_test_pkg;

   typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
   typedef logic [`WORD_W-1:0]     word_t;
   typedef logic [`PC_W-1:0]       upc_t;
   typedef logic [`UINSTR_W-1:0]   uinstr_t;   // op, dst, src, target, immediate

   typedef enum logic [`UOP_W-1:0] {
      OP_NOP   = 4'd0,
      OP_WRITE = 4'd1,
      OP_READ  = 4'd2,
      OP_ADD   = 4'd3,
      OP_SUB   = 4'd4,
      OP_TST   = 4'd5,    // branch when masked bits are zero
      OP_CMP   = 4'd6,    // branch on equal
      OP_JMP   = 4'd7,
      OP_DONE  = 4'd8,
      OP_WAIT  = 4'd9,
      OP_FAULT = 4'd15
   } uop_e;

   typedef enum logic [`REG_SEL_W-1:0] {
      R_NONE = 3'd0,
      R_A    = 3'd1,      // address
      R_B    = 3'd2,      // count
      R_C    = 3'd3,
      R_D    = 3'd4,      // data
      R_I    = 3'd5,      // immediate
      R_P    = 3'd7       // pattern rom output
   } reg_sel_e;

endpackage

/* source/pattern_rom.sv */
// expected data word for a block offset
// registered one cycle behind the offset
`timescale 1ns/1ps

module pattern_rom (
   input  logic                clk,
   input  logic                reset,
   input  logic [7:0]          offset,
   output cpu_test_pkg::word_t data
);

   logic [7:0] inv_byte;
   logic [7:0] mix_byte;
   logic [7:0] sum_byte;

   assign inv_byte = ~offset;
   assign mix_byte = offset ^ 8'h5a;
   assign sum_byte = offset + 8'h3c;   // wraps within the byte

   always_ff @(posedge clk)
   begin
      if (reset)
         data <= '0;
      else
         data <= {offset, inv_byte, mix_byte, sum_byte};
   end

endmodule

/* source/ucode_rom.sv */
// micro-program rom of the bus test cpu
// fill block, wait, poll status, read back and compare, then DONE or FAULT
`timescale 1ns/1ps
`include "cpu_test_defines.svh"

module ucode_rom (
   input  logic                  clk,
   input  logic                  reset,
   input  cpu_test_pkg::upc_t    addr,
   output cpu_test_pkg::uinstr_t data
);

   function automatic cpu_test_pkg::uinstr_t uc(input cpu_test_pkg::uop_e op,
                                                input cpu_test_pkg::reg_sel_e dst,
                                                input cpu_test_pkg::reg_sel_e src,
                                                input logic [`TARGET_W-1:0] target,
                                                input cpu_test_pkg::word_t imm);
      return {op, dst, src, target, imm};
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
         data <= '0;   // nop
      else
      begin
         case (addr)
            // fill the block with pattern data
            8'h00: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_A, cpu_test_pkg::R_NONE,
                              6'h00, `BLOCK_BASE);   // a = base
            8'h01: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_B, cpu_test_pkg::R_NONE,
                              6'h00, 32'h0);         // b = 0
            8'h02: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_D, cpu_test_pkg::R_P,
                              6'h00, 32'h0);         // d = pattern
            8'h03: data <= uc(cpu_test_pkg::OP_WRITE, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            8'h04: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_A, cpu_test_pkg::R_A,
                              6'h00, 32'h1);         // a++
            8'h05: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_B, cpu_test_pkg::R_B,
                              6'h00, 32'h1);         // b++
            8'h06: data <= uc(cpu_test_pkg::OP_CMP, cpu_test_pkg::R_B, cpu_test_pkg::R_I,
                              6'h08, `BLOCK_WORDS);
            8'h07: data <= uc(cpu_test_pkg::OP_JMP, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h02, 32'h0);
            // settle, then poll until busy clears
            8'h08: data <= uc(cpu_test_pkg::OP_WAIT, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            8'h09: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_A, cpu_test_pkg::R_NONE,
                              6'h00, `STATUS_ADDR);
            8'h0a: data <= uc(cpu_test_pkg::OP_READ, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            8'h0b: data <= uc(cpu_test_pkg::OP_TST, cpu_test_pkg::R_D, cpu_test_pkg::R_I,
                              6'h0d, 32'h1);         // busy clear
            8'h0c: data <= uc(cpu_test_pkg::OP_JMP, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h0a, 32'h0);
            // read back and compare
            8'h0d: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_A, cpu_test_pkg::R_NONE,
                              6'h00, `BLOCK_BASE);
            8'h0e: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_B, cpu_test_pkg::R_NONE,
                              6'h00, 32'h0);
            8'h0f: data <= uc(cpu_test_pkg::OP_READ, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            8'h10: data <= uc(cpu_test_pkg::OP_CMP, cpu_test_pkg::R_D, cpu_test_pkg::R_P,
                              6'h12, 32'h0);         // d == pattern
            8'h11: data <= uc(cpu_test_pkg::OP_FAULT, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            8'h12: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_A, cpu_test_pkg::R_A,
                              6'h00, 32'h1);
            8'h13: data <= uc(cpu_test_pkg::OP_ADD, cpu_test_pkg::R_B, cpu_test_pkg::R_B,
                              6'h00, 32'h1);
            8'h14: data <= uc(cpu_test_pkg::OP_CMP, cpu_test_pkg::R_B, cpu_test_pkg::R_I,
                              6'h16, `BLOCK_WORDS);
            8'h15: data <= uc(cpu_test_pkg::OP_JMP, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h0f, 32'h0);
            8'h16: data <= uc(cpu_test_pkg::OP_DONE, cpu_test_pkg::R_NONE,
                              cpu_test_pkg::R_NONE, 6'h00, 32'h0);
            default: data <= uc(cpu_test_pkg::OP_JMP, cpu_test_pkg::R_NONE,
                                cpu_test_pkg::R_NONE, 6'h00, 32'h0);
         endcase
      end
   end

endmodule

/* source/test_cpu.sv */
// microcoded test cpu
// registers a..d, add/sub alu, tst/cmp branches, wait counter and bus requests
// the micro-rom and pattern rom sit outside and answer one cycle after their address
`timescale 1ns/1ps
`include "cpu_test_defines.svh"

module test_cpu (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   output logic                    done,
   output logic                    fault,
   output cpu_test_pkg::upc_t      pc,
   output cpu_test_pkg::upc_t      uaddr,
   input  cpu_test_pkg::uinstr_t   uinstr,
   output logic [7:0]              pat_offset,
   input  cpu_test_pkg::word_t     pat_data,
   output logic                    mem_rq,
   output logic                    mem_wr,
   output cpu_test_pkg::bus_addr_t mem_addr,
   output cpu_test_pkg::word_t     mem_wdata,
   input  logic                    mem_ack,
   input  logic                    mem_done,
   input  cpu_test_pkg::word_t     mem_rdata
);

   localparam int WAIT_W = $clog2(`WAIT_CYCLES);

   cpu_test_pkg::uop_e      op;
   cpu_test_pkg::reg_sel_e  dst_sel;
   cpu_test_pkg::reg_sel_e  src_sel;
   cpu_test_pkg::upc_t      target;
   cpu_test_pkg::word_t     imm;
   cpu_test_pkg::upc_t      npc;
   cpu_test_pkg::bus_addr_t a;
   cpu_test_pkg::bus_addr_t a_offset;
   cpu_test_pkg::word_t     b;
   cpu_test_pkg::word_t     c;
   cpu_test_pkg::word_t     d;
   cpu_test_pkg::word_t     src;
   cpu_test_pkg::word_t     dst;
   cpu_test_pkg::word_t     alu_out;
   logic [WAIT_W-1:0]       wait_count;
   logic                    wait_done;
   logic                    is_mem;
   logic                    is_alu;
   logic                    stall_pc;
   logic                    load_pc;
   logic                    tst_hit;
   logic                    cmp_hit;

   // field split from the msb down
   assign op      = cpu_test_pkg::uop_e'(uinstr[47:44]);
   assign dst_sel = cpu_test_pkg::reg_sel_e'(uinstr[43:41]);
   assign src_sel = cpu_test_pkg::reg_sel_e'(uinstr[40:38]);
   assign target  = cpu_test_pkg::upc_t'(uinstr[37:32]);
   assign imm     = uinstr[31:0];

   always_comb
   begin
      case (src_sel)
         cpu_test_pkg::R_A: src = cpu_test_pkg::word_t'(a);
         cpu_test_pkg::R_B: src = b;
         cpu_test_pkg::R_C: src = c;
         cpu_test_pkg::R_D: src = d;
         cpu_test_pkg::R_I: src = imm;
         cpu_test_pkg::R_P: src = pat_data;
         default:           src = '0;
      endcase
   end

   always_comb
   begin
      case (dst_sel)
         cpu_test_pkg::R_A: dst = cpu_test_pkg::word_t'(a);
         cpu_test_pkg::R_B: dst = b;
         cpu_test_pkg::R_C: dst = c;
         cpu_test_pkg::R_D: dst = d;
         default:           dst = '0;
      endcase
   end

   assign is_alu  = op == cpu_test_pkg::OP_ADD || op == cpu_test_pkg::OP_SUB;
   assign alu_out = (op == cpu_test_pkg::OP_SUB) ? src - imm : src + imm;

   // registers only change when the micro-op retires
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         a <= '0;
         b <= '0;
         c <= '0;
      end
      else if (is_alu && !stall_pc)
      begin
         case (dst_sel)
            cpu_test_pkg::R_A: a <= alu_out[`BUS_ADDR_W-1:0];
            cpu_test_pkg::R_B: b <= alu_out;
            cpu_test_pkg::R_C: c <= alu_out;
            default:           ;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (op == cpu_test_pkg::OP_READ && mem_done)
         d <= mem_rdata;
      else if (is_alu && !stall_pc && dst_sel == cpu_test_pkg::R_D)
         d <= alu_out;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         wait_count <= '0;
      else if (op == cpu_test_pkg::OP_WAIT && !wait_done)
         wait_count <= wait_count + 1'b1;
      else
         wait_count <= '0;
   end

   assign wait_done = wait_count == WAIT_W'(`WAIT_CYCLES - 1);

   assign tst_hit = ~|(dst & src);
   assign cmp_hit = dst == src;
   assign is_mem  = op == cpu_test_pkg::OP_READ || op == cpu_test_pkg::OP_WRITE;

   assign stall_pc = !start ||
                     op == cpu_test_pkg::OP_DONE || op == cpu_test_pkg::OP_FAULT ||
                     (op == cpu_test_pkg::OP_WAIT && !wait_done) ||
                     (op == cpu_test_pkg::OP_WRITE && !mem_ack) ||
                     (op == cpu_test_pkg::OP_READ && !mem_done);

   assign load_pc = (op == cpu_test_pkg::OP_TST && tst_hit) ||
                    (op == cpu_test_pkg::OP_CMP && cmp_hit) ||
                    op == cpu_test_pkg::OP_JMP;

   assign npc   = load_pc ? target : pc + 1'b1;
   assign uaddr = stall_pc ? pc : npc;   // rom replays the current op on a stall

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '1;
      else if (!stall_pc)
         pc <= npc;
   end

   // request drops the cycle after its strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mem_rq <= 1'b0;
         mem_wr <= 1'b0;
      end
      else
      begin
         mem_rq <= is_mem && !mem_ack && !mem_done;
         mem_wr <= op == cpu_test_pkg::OP_WRITE && !mem_ack;
      end
   end

   assign a_offset   = a - `BLOCK_BASE;
   assign pat_offset = a_offset[7:0];
   assign mem_addr   = a;
   assign mem_wdata  = d;
   assign done       = op == cpu_test_pkg::OP_DONE;
   assign fault      = op == cpu_test_pkg::OP_FAULT;

   bus_stable: assert property (@(posedge clk) disable iff (reset)
         mem_rq |=> !mem_rq || ($stable(mem_addr) && $stable(mem_wdata)))
      else $error("bus address or data moved during a request at %t", $time);

   halt_hold: assert property (@(posedge clk) disable iff (reset)
         (done || fault) |=> $stable({done, fault}) && !(done && fault))
      else $error("done/fault not held exclusively at %t", $time);

endmodule

/* source/cpu_test_top.sv */
// top of the bus test sequencer
// test cpu with its micro-rom and pattern rom, bus on plain ports
`timescale 1ns/1ps

module cpu_test_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   output logic                    done,
   output logic                    fault,
   output cpu_test_pkg::upc_t      pc,
   output logic                    mem_rq,
   output logic                    mem_wr,
   output cpu_test_pkg::bus_addr_t mem_addr,
   output cpu_test_pkg::word_t     mem_wdata,
   input  logic                    mem_ack,
   input  logic                    mem_done,
   input  cpu_test_pkg::word_t     mem_rdata
);

   cpu_test_pkg::upc_t    uaddr;
   cpu_test_pkg::uinstr_t uinstr;
   logic [7:0]            pat_offset;
   cpu_test_pkg::word_t   pat_data;

   test_cpu cpu_inst (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .done       (done),
      .fault      (fault),
      .pc         (pc),
      .uaddr      (uaddr),
      .uinstr     (uinstr),
      .pat_offset (pat_offset),
      .pat_data   (pat_data),
      .mem_rq     (mem_rq),
      .mem_wr     (mem_wr),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ack    (mem_ack),
      .mem_done   (mem_done),
      .mem_rdata  (mem_rdata)
   );

   ucode_rom ucode_rom_inst (
      .clk   (clk),
      .reset (reset),
      .addr  (uaddr),
      .data  (uinstr)
   );

   pattern_rom pattern_rom_inst (
      .clk    (clk),
      .reset  (reset),
      .offset (pat_offset),
      .data   (pat_data)
   );

endmodule

/* test/mem_model.sv */
// behavioral peripheral for the bus test sequencer
// block memory, status register with a busy bit, random strobe latency
// and an optional corrupted word on read-back
`timescale 1ns/1ps
`include "cpu_test_defines.svh"

module mem_model (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [3:0]              busy_polls,
   input  logic                    corrupt_en,
   input  logic [5:0]              corrupt_index,
   input  logic                    mem_rq,
   input  logic                    mem_wr,
   input  cpu_test_pkg::bus_addr_t mem_addr,
   input  cpu_test_pkg::word_t     mem_wdata,
   output logic                    mem_ack,
   output logic                    mem_done,
   output cpu_test_pkg::word_t     mem_rdata
);

   localparam int DRIVE_DELAY = 1;

   cpu_test_pkg::word_t block_mem [`BLOCK_WORDS];
   int                  poll_count = 0;
   int                  delay = 0;
   logic                pending = 1'b0;
   logic                answered = 1'b0;

   initial
   begin
      mem_ack   = 1'b0;
      mem_done  = 1'b0;
      mem_rdata = '0;
   end

   task automatic answer_request();
      logic       in_block;
      logic [5:0] idx;
      in_block = mem_addr >= `BLOCK_BASE && mem_addr < `BLOCK_BASE + `BLOCK_WORDS;
      idx      = 6'(mem_addr - `BLOCK_BASE);
      if (mem_wr)
      begin
         if (in_block)
            block_mem[idx] = mem_wdata;
         mem_ack = 1'b1;
      end
      else
      begin
         if (mem_addr == `STATUS_ADDR)
         begin
            mem_rdata  = cpu_test_pkg::word_t'(poll_count < int'(busy_polls));  // busy
            poll_count = poll_count + 1;
         end
         else if (in_block)
            mem_rdata = block_mem[idx] ^ {31'b0, corrupt_en && idx == corrupt_index};
         else
            mem_rdata = '0;
         mem_done = 1'b1;
      end
   endtask

   // one answer per high-going request
   always @(posedge clk)
   begin
      #DRIVE_DELAY;
      mem_ack  = 1'b0;
      mem_done = 1'b0;
      if (reset)
      begin
         poll_count = 0;
         pending    = 1'b0;
         answered   = 1'b0;
      end
      else if (!mem_rq)
      begin
         pending  = 1'b0;
         answered = 1'b0;
      end
      else if (!answered)
      begin
         if (!pending)
         begin
            pending = 1'b1;
            delay   = int'($urandom_range(7, 0));
         end
         if (delay == 0)
         begin
            answered = 1'b1;
            answer_request();
         end
         else
            delay = delay - 1;
      end
   end

endmodule

/* test/cpu_test_top_tb.sv */
// testbench for the bus test sequencer
// a clean run and then a run with one corrupted block word
`timescale 1ns/1ps
`include "cpu_test_defines.svh"

module cpu_test_top_tb;

   localparam int HALF_PERIOD  = 50;
   localparam int DRIVE_DELAY  = 1;
   localparam int RESET_CYCLES = 8;
   localparam int IDLE_CYCLES  = 5;
   localparam int HOLD_CYCLES  = 6;
   localparam int HALT_TIMEOUT = 20000;
   localparam int CORRUPT_WORD = 37;

   logic                    clk = 1'b0;
   logic                    reset = 1'b1;
   logic                    start = 1'b0;
   logic                    done;
   logic                    fault;
   cpu_test_pkg::upc_t      pc;
   logic                    mem_rq;
   logic                    mem_wr;
   cpu_test_pkg::bus_addr_t mem_addr;
   cpu_test_pkg::word_t     mem_wdata;
   logic                    mem_ack;
   logic                    mem_done;
   cpu_test_pkg::word_t     mem_rdata;
   logic [3:0]              busy_polls = 4'd1;
   logic                    corrupt_en = 1'b0;
   logic                    write_strobe;
   logic                    status_read;
   logic                    block_read;
   int                      write_count;
   int                      block_reads;
   int                      status_reads;
   cpu_test_pkg::bus_addr_t last_read_addr;
   int                      error_count = 0;
   int unsigned             seed_value;
   logic                    timed_out;

   always #HALF_PERIOD clk = ~clk;

   cpu_test_top cpu_test_top_inst (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .done      (done),
      .fault     (fault),
      .pc        (pc),
      .mem_rq    (mem_rq),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_ack   (mem_ack),
      .mem_done  (mem_done),
      .mem_rdata (mem_rdata)
   );

   mem_model mem_model_inst (
      .clk           (clk),
      .reset         (reset),
      .busy_polls    (busy_polls),
      .corrupt_en    (corrupt_en),
      .corrupt_index (6'(CORRUPT_WORD)),
      .mem_rq        (mem_rq),
      .mem_wr        (mem_wr),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_ack       (mem_ack),
      .mem_done      (mem_done),
      .mem_rdata     (mem_rdata)
   );

   // byte i, inverted byte, i xor 0x5a, i plus 0x3c
   function automatic cpu_test_pkg::word_t pattern_word(input int offset);
      logic [7:0] i;
      i = offset[7:0];
      return {i, ~i, i ^ 8'h5a, i + 8'h3c};
   endfunction

   function automatic cpu_test_pkg::bus_addr_t block_addr(input int offset);
      return cpu_test_pkg::bus_addr_t'(`BLOCK_BASE + offset);
   endfunction

   task automatic record_failure(input string msg);
      error_count = error_count + 1;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   assign write_strobe = mem_rq && mem_wr && mem_ack;
   assign status_read  = mem_rq && !mem_wr && mem_done && mem_addr == `STATUS_ADDR;
   assign block_read   = mem_rq && !mem_wr && mem_done && mem_addr != `STATUS_ADDR;

   always @(posedge clk)
   begin
      if (reset)
      begin
         write_count    <= 0;
         block_reads    <= 0;
         status_reads   <= 0;
         last_read_addr <= '0;
      end
      else
      begin
         if (write_strobe)
            write_count <= write_count + 1;
         if (status_read)
            status_reads <= status_reads + 1;
         if (block_read)
         begin
            block_reads    <= block_reads + 1;
            last_read_addr <= mem_addr;
         end
      end
   end

   idle_before_start: assert property (@(posedge clk) disable iff (reset)
         !start |-> !done && !fault && !mem_rq)
      else record_failure("done, fault or mem_rq high before start");

   pc_hold: assert property (@(posedge clk) disable iff (reset) !start |=> $stable(pc))
      else record_failure("pc moved while start was low");

   fill_write: assert property (@(posedge clk) disable iff (reset)
         write_strobe |-> mem_addr == block_addr(write_count) &&
                          mem_wdata == pattern_word(write_count))
      else record_failure("fill write has wrong address or data");

   fill_bound: assert property (@(posedge clk) disable iff (reset)
         mem_rq && mem_wr |-> write_count < `BLOCK_WORDS)
      else record_failure("more fill writes than block words");

   fill_complete: assert property (@(posedge clk) disable iff (reset)
         status_read |-> write_count == `BLOCK_WORDS)
      else record_failure("status polled before the whole block was written");

   rq_hold: assert property (@(posedge clk) disable iff (reset)
         mem_rq && !mem_ack && !mem_done |=>
            mem_rq && $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_wr))
      else record_failure("request dropped or changed before its strobe");

   rq_drop: assert property (@(posedge clk) disable iff (reset)
         mem_ack || mem_done |=> !mem_rq)
      else record_failure("mem_rq still high the cycle after its strobe");

   poll_count: assert property (@(posedge clk) disable iff (reset)
         block_read && block_reads == 0 |-> status_reads == int'(busy_polls) + 1)
      else record_failure("status read count differs from busy polls plus one");

   read_order: assert property (@(posedge clk) disable iff (reset)
         block_read |-> mem_addr == block_addr(block_reads))
      else record_failure("block read-back out of order");

   clean_done: assert property (@(posedge clk) disable iff (reset)
         done |-> !corrupt_en && !fault && block_reads == `BLOCK_WORDS)
      else record_failure("done without a clean read of every block word");

   done_hold: assert property (@(posedge clk) disable iff (reset) done |=> done)
      else record_failure("done fell before reset");

   fault_site: assert property (@(posedge clk) disable iff (reset)
         fault |-> corrupt_en && last_read_addr == block_addr(CORRUPT_WORD) &&
                   block_reads == CORRUPT_WORD + 1)
      else record_failure("fault raised at the wrong word or without corruption");

   fault_hold: assert property (@(posedge clk) disable iff (reset) fault |=> fault)
      else record_failure("fault fell before reset");

   task automatic run_once(input logic corrupt, output logic run_timed_out);
      int cycles;
      reset      = 1'b1;
      start      = 1'b0;
      corrupt_en = corrupt;
      busy_polls = 4'($urandom_range(6, 1));
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY reset = 1'b0;
      repeat (IDLE_CYCLES) @(posedge clk);   // pc must hold here
      #DRIVE_DELAY start = 1'b1;
      cycles = 0;
      while (!done && !fault && cycles < HALT_TIMEOUT)
      begin
         @(posedge clk);
         #DRIVE_DELAY;
         cycles = cycles + 1;
      end
      run_timed_out = !done && !fault;
      if (run_timed_out)
      begin
         error_count = error_count + 1;
         $display("timeout: no done or fault within %0d cycles", HALT_TIMEOUT);
      end
      else
      begin
         repeat (HOLD_CYCLES) @(posedge clk);
         #DRIVE_DELAY;
      end
   endtask

   task automatic report_result();
      $display("errors: %0d", error_count);
      if (error_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   endtask

   initial
   begin
      seed_value = $urandom(32'h98622c9a);
      run_once(1'b0, timed_out);
      if (!timed_out)
         run_once(1'b1, timed_out);   // word CORRUPT_WORD reads back wrong
      report_result();
   end

endmodule

/* cpu_test_top.f */
+incdir+source
source/cpu_test_pkg.sv
source/pattern_rom.sv
source/ucode_rom.sv
source/test_cpu.sv
source/cpu_test_top.sv
test/mem_model.sv
test/cpu_test_top_tb.sv

/* Makefile */
# Verilator build, run and lint of the bus test sequencer

VERILATOR  ?= verilator
TB_TOP     ?= cpu_test_top_tb
FILELIST   ?= cpu_test_top.f
BUILD_DIR  ?= build
PASS_MSG   ?= Test passed
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --timing --assert -Wall

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

# the run passes only when the pass line shows up in the output
run: build
	./$(SIM_BIN) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
